// File: files.f
src/md_pkg.sv
src/md_ifs.sv
src/cell_loader.sv
src/pair_filter.sv
src/force_lookup.sv
src/force_accumulator.sv
src/md_pair_top.sv
test/md_pair_props.sv
test/md_pair_tb.sv

// File: src/cell_loader.sv
`default_nettype none

module cell_loader import md_pkg::*; (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic load_valid,
	input  wire logic load_neighbor,	// 1 appends to the neighbor cell
	input  wire pos_t load_x,
	input  wire pos_t load_y,
	input  wire pos_t load_z,
	input  wire logic clear,
	input  wire logic start,
	output logic      busy,
	output logic      empty_start,	// Start seen with an empty cell
	pair_if.source    pairs
);

	// Last pair leaves here, force_valid follows 4 cycles later
	localparam int DRAIN_CYC = 4;

	logic [2:0][POS_W-1:0] home_mem [MAX_PARTICLES];	// [2] x, [1] y, [0] z
	logic [2:0][POS_W-1:0] nbr_mem [MAX_PARTICLES];

	logic [CNT_W-1:0] home_cnt, nbr_cnt;
	logic [IDX_W-1:0] hi, ni;	// Sweep indices
	logic             sweep;
	logic [2:0]       drain;
	logic             load_ok, last_home, last_nbr, start_run;

	assign load_ok     = load_valid && !busy && !clear;	// Clear wins over a load
	assign last_home   = ({1'b0, hi} == home_cnt - 1'b1);
	assign last_nbr    = ({1'b0, ni} == nbr_cnt - 1'b1);
	assign start_run   = start && !busy && (home_cnt != '0) && (nbr_cnt != '0);
	assign empty_start = start && !busy && ((home_cnt == '0) || (nbr_cnt == '0));

	always_ff @(posedge clk) begin
		if (load_ok && load_neighbor && (nbr_cnt != CNT_W'(MAX_PARTICLES)))
			nbr_mem[nbr_cnt[IDX_W-1:0]] <= {load_x, load_y, load_z};
		if (load_ok && !load_neighbor && (home_cnt != CNT_W'(MAX_PARTICLES)))
			home_mem[home_cnt[IDX_W-1:0]] <= {load_x, load_y, load_z};
	end

	// Pair positions are plain payload
	always_ff @(posedge clk) begin
		{pairs.home_x, pairs.home_y, pairs.home_z} <= home_mem[hi];
		{pairs.nbr_x, pairs.nbr_y, pairs.nbr_z}    <= nbr_mem[ni];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			home_cnt           <= '0;
			nbr_cnt            <= '0;
			busy               <= 1'b0;
			sweep              <= 1'b0;
			drain              <= '0;
			hi                 <= '0;
			ni                 <= '0;
			pairs.valid        <= 1'b0;
			pairs.home_idx     <= '0;
			pairs.last_of_home <= 1'b0;
			pairs.last_of_run  <= 1'b0;
		end else begin
			if (clear && !busy) begin
				home_cnt <= '0;
				nbr_cnt  <= '0;
			end else if (load_ok && load_neighbor) begin
				if (nbr_cnt != CNT_W'(MAX_PARTICLES))
					nbr_cnt <= nbr_cnt + 1'b1;
			end else if (load_ok) begin
				if (home_cnt != CNT_W'(MAX_PARTICLES))
					home_cnt <= home_cnt + 1'b1;
			end

			pairs.valid        <= sweep;
			pairs.home_idx     <= hi;
			pairs.last_of_home <= sweep && last_nbr;
			pairs.last_of_run  <= sweep && last_nbr && last_home;

			if (sweep) begin	// Home-major walk
				if (last_nbr) begin
					ni <= '0;
					if (last_home) begin
						sweep <= 1'b0;
						drain <= 3'(DRAIN_CYC);
					end else begin
						hi <= hi + 1'b1;
					end
				end else begin
					ni <= ni + 1'b1;
				end
			end else if (drain != '0) begin
				drain <= drain - 1'b1;
				if (drain == 3'd1)
					busy <= 1'b0;	// Low together with done
			end else if (start_run) begin
				busy  <= 1'b1;
				sweep <= 1'b1;
				hi    <= '0;
				ni    <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/force_accumulator.sv
`default_nettype none

module force_accumulator import md_pkg::*; (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic        empty_start,	// Run with nothing to sweep
	contrib_if.force_sink    contrib_in,
	output logic             force_valid,
	output logic [IDX_W-1:0] force_home_idx,
	output force_t           force_x,
	output force_t           force_y,
	output force_t           force_z,
	output logic             done
);

	force_t sum_x, sum_y, sum_z;
	force_t next_x, next_y, next_z;
	logic   home_end;

	assign home_end = contrib_in.valid && contrib_in.last_of_home;

	always_comb begin
		next_x = sum_x + contrib_in.dx;
		next_y = sum_y + contrib_in.dy;
		next_z = sum_z + contrib_in.dz;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum_x          <= '0;
			sum_y          <= '0;
			sum_z          <= '0;
			force_valid    <= 1'b0;
			force_home_idx <= '0;
			done           <= 1'b0;
		end else begin
			force_valid <= home_end;
			done        <= (home_end && contrib_in.last_of_run) || empty_start;
			if (home_end) begin
				force_home_idx <= contrib_in.home_idx;
				sum_x          <= '0;	// Next home particle starts clean
				sum_y          <= '0;
				sum_z          <= '0;
			end else if (contrib_in.valid) begin
				sum_x <= next_x;
				sum_y <= next_y;
				sum_z <= next_z;
			end
		end
	end

	// Totals are only meaningful under force_valid
	always_ff @(posedge clk) begin
		if (home_end) begin
			force_x <= next_x;
			force_y <= next_y;
			force_z <= next_z;
		end
	end

endmodule

`default_nettype wire

// File: src/force_lookup.sv
`default_nettype none

module force_lookup import md_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst_n,
	contrib_if.sink         contrib_in,
	contrib_if.force_source contrib_out
);

	localparam int TBL_DEPTH = 2 ** TBL_W;

	coef_t                  coef_tbl [TBL_DEPTH];
	coef_t                  coef;
	logic signed [COEF_W:0] coef_s;	// Zero extended so the multiply stays signed
	force_t                 prod_x, prod_y, prod_z;

	initial begin
		for (int i = 0; i < TBL_DEPTH; i++)
			coef_tbl[i] = coef_of(TBL_W'(i));
	end

	always_comb begin
		coef   = coef_tbl[contrib_in.r2.tbl.index];
		coef_s = $signed({1'b0, coef});
		prod_x = (contrib_in.dx * coef_s) >>> COEF_SHIFT;
		prod_y = (contrib_in.dy * coef_s) >>> COEF_SHIFT;
		prod_z = (contrib_in.dz * coef_s) >>> COEF_SHIFT;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			contrib_out.valid        <= 1'b0;
			contrib_out.last_of_home <= 1'b0;
			contrib_out.last_of_run  <= 1'b0;
			contrib_out.home_idx     <= '0;
		end else begin
			contrib_out.valid        <= contrib_in.valid;
			contrib_out.last_of_home <= contrib_in.last_of_home;
			contrib_out.last_of_run  <= contrib_in.last_of_run;
			contrib_out.home_idx     <= contrib_in.home_idx;
		end
	end

	// Out of range pairs still flow, with zero force
	always_ff @(posedge clk) begin
		contrib_out.dx <= contrib_in.in_range ? prod_x : '0;
		contrib_out.dy <= contrib_in.in_range ? prod_y : '0;
		contrib_out.dz <= contrib_in.in_range ? prod_z : '0;
	end

endmodule

`default_nettype wire

// File: src/md_ifs.sv
`default_nettype none

// Pair stream from the loader into the filter
interface pair_if import md_pkg::*; ();

	logic             valid;
	logic [IDX_W-1:0] home_idx;
	logic             last_of_home;	// Final neighbor of this home particle
	logic             last_of_run;	// Final pair of the whole sweep
	pos_t             home_x, home_y, home_z;
	pos_t             nbr_x, nbr_y, nbr_z;

	modport source (output valid, home_idx, last_of_home, last_of_run,
		home_x, home_y, home_z, nbr_x, nbr_y, nbr_z);
	modport sink (input valid, home_idx, last_of_home, last_of_run,
		home_x, home_y, home_z, nbr_x, nbr_y, nbr_z);

endinterface

// Per-pair contribution stream; comp_t is disp_t before the lookup, force_t after
interface contrib_if import md_pkg::*; #(parameter type comp_t = disp_t) ();

	logic             valid;
	logic [IDX_W-1:0] home_idx;
	logic             last_of_home;
	logic             last_of_run;
	logic             in_range;
	comp_t            dx, dy, dz;
	r2_word_u         r2;

	// Filter to lookup, with r2
	modport source (output valid, home_idx, last_of_home, last_of_run, in_range,
		dx, dy, dz, r2);
	modport sink (input valid, home_idx, last_of_home, last_of_run, in_range,
		dx, dy, dz, r2);

	// Lookup to accumulator, contributions already zeroed out of range
	modport force_source (output valid, home_idx, last_of_home, last_of_run, dx, dy, dz);
	modport force_sink (input valid, home_idx, last_of_home, last_of_run, dx, dy, dz);

endinterface

`default_nettype wire

// File: src/md_pair_top.sv
`default_nettype none

module md_pair_top import md_pkg::*; #(
	parameter int BOX_SIZE = 640,	// Must stay below 1024
	parameter int CUTOFF_2 = 40000
) (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic        load_valid,
	input  wire logic        load_neighbor,
	input  wire pos_t        load_x,
	input  wire pos_t        load_y,
	input  wire pos_t        load_z,
	input  wire logic        clear,
	input  wire logic        start,
	output logic             busy,
	output logic             force_valid,
	output logic [IDX_W-1:0] force_home_idx,
	output force_t           force_x,
	output force_t           force_y,
	output force_t           force_z,
	output logic             done
);

	logic empty_start;

	pair_if                        pairs();
	contrib_if #(.comp_t(disp_t))  disp_bus();	// Displacements and r2
	contrib_if #(.comp_t(force_t)) force_bus();	// Scaled contributions

	cell_loader u_loader (
		.clk(clk), .rst_n(rst_n),
		.load_valid(load_valid), .load_neighbor(load_neighbor),
		.load_x(load_x), .load_y(load_y), .load_z(load_z),
		.clear(clear), .start(start),
		.busy(busy), .empty_start(empty_start),
		.pairs(pairs.source)
	);

	pair_filter #(.BOX_SIZE(BOX_SIZE), .CUTOFF_2(CUTOFF_2)) u_filter (
		.clk(clk), .rst_n(rst_n),
		.pairs(pairs.sink),
		.contrib_out(disp_bus.source)
	);

	force_lookup u_lookup (
		.clk(clk), .rst_n(rst_n),
		.contrib_in(disp_bus.sink),
		.contrib_out(force_bus.force_source)
	);

	force_accumulator u_accum (
		.clk(clk), .rst_n(rst_n),
		.empty_start(empty_start),
		.contrib_in(force_bus.force_sink),
		.force_valid(force_valid), .force_home_idx(force_home_idx),
		.force_x(force_x), .force_y(force_y), .force_z(force_z),
		.done(done)
	);

endmodule

`default_nettype wire

// File: src/md_pkg.sv
`default_nettype none

package md_pkg;

	localparam int POS_W         = 10;
	localparam int MAX_PARTICLES = 32;
	localparam int IDX_W         = 5;
	localparam int CNT_W         = IDX_W + 1;	// Counts run 0..MAX_PARTICLES
	localparam int DISP_W        = POS_W + 1;
	localparam int R2_W          = 20;
	localparam int TBL_W         = 12;
	localparam int FRAC_W        = R2_W - TBL_W;
	localparam int COEF_W        = 12;
	localparam int FORCE_W       = 32;
	localparam int COEF_SHIFT    = 8;	// Fraction bits of the coefficient product

	// Unsigned fixed point coordinate, one axis
	typedef logic [POS_W-1:0] pos_t;

	// Wrapped displacement, one axis
	typedef logic signed [DISP_W-1:0] disp_t;

	// Squared distance, read raw for the cutoff and split for the table
	typedef union packed {
		logic [R2_W-1:0] raw;
		struct packed {
			logic [TBL_W-1:0]  index;	// Upper bits select the table entry
			logic [FRAC_W-1:0] frac;
		} tbl;
	} r2_word_u;

	typedef logic [COEF_W-1:0] coef_t;

	typedef logic signed [FORCE_W-1:0] force_t;

	// Force falls off linearly with the table index
	function automatic coef_t coef_of(input logic [TBL_W-1:0] index);
		return coef_t'({COEF_W{1'b1}} - index);
	endfunction

endpackage

`default_nettype wire

// File: src/pair_filter.sv
`default_nettype none

module pair_filter import md_pkg::*; #(
	parameter int BOX_SIZE = 640,
	parameter int CUTOFF_2 = 40000
) (
	input  wire logic clk,
	input  wire logic rst_n,
	pair_if.sink      pairs,
	contrib_if.source contrib_out
);

	localparam disp_t BOX_D     = disp_t'(BOX_SIZE);
	localparam disp_t HALF_D    = disp_t'(BOX_SIZE / 2);
	localparam disp_t NEG_HALF_D = -HALF_D;

	// Minimum image along one axis
	function automatic disp_t wrap(input pos_t home, input pos_t nbr);
		disp_t d;
		d = $signed({1'b0, home}) - $signed({1'b0, nbr});
		if (d > HALF_D)
			d = d - BOX_D;
		else if (d < NEG_HALF_D)
			d = d + BOX_D;
		return d;
	endfunction

	logic             s1_valid, s1_loh, s1_lor;
	logic [IDX_W-1:0] s1_idx;
	disp_t            s1_dx, s1_dy, s1_dz;

	logic signed [2*DISP_W-1:0] sq_x, sq_y, sq_z;
	logic [2*DISP_W-1:0]        r2_sum;

	always_comb begin
		sq_x   = s1_dx * s1_dx;
		sq_y   = s1_dy * s1_dy;
		sq_z   = s1_dz * s1_dz;
		r2_sum = sq_x + sq_y + sq_z;	// Fits in R2_W bits for any box below 1024
	end

	// Stage one, wrapped displacements
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s1_loh   <= 1'b0;
			s1_lor   <= 1'b0;
			s1_idx   <= '0;
		end else begin
			s1_valid <= pairs.valid;
			s1_loh   <= pairs.last_of_home;
			s1_lor   <= pairs.last_of_run;
			s1_idx   <= pairs.home_idx;
		end
	end

	always_ff @(posedge clk) begin
		s1_dx <= wrap(pairs.home_x, pairs.nbr_x);
		s1_dy <= wrap(pairs.home_y, pairs.nbr_y);
		s1_dz <= wrap(pairs.home_z, pairs.nbr_z);
	end

	// Stage two, r2 and cutoff
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			contrib_out.valid        <= 1'b0;
			contrib_out.last_of_home <= 1'b0;
			contrib_out.last_of_run  <= 1'b0;
			contrib_out.home_idx     <= '0;
			contrib_out.in_range     <= 1'b0;
		end else begin
			contrib_out.valid        <= s1_valid;
			contrib_out.last_of_home <= s1_loh;
			contrib_out.last_of_run  <= s1_lor;
			contrib_out.home_idx     <= s1_idx;
			contrib_out.in_range     <= (r2_sum < CUTOFF_2) && (r2_sum != '0);	// Self pair excluded
		end
	end

	always_ff @(posedge clk) begin
		contrib_out.dx     <= s1_dx;
		contrib_out.dy     <= s1_dy;
		contrib_out.dz     <= s1_dz;
		contrib_out.r2.raw <= r2_sum[R2_W-1:0];
	end

endmodule

`default_nettype wire

// File: test/md_pair_props.sv
`default_nettype none

module md_pair_props (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic busy,
	input wire logic force_valid,
	input wire logic done
);

	timeunit 1ns;
	timeprecision 100ps;

	// The last force_valid shares its cycle with the falling busy
	force_in_run: assert property (@(posedge clk) disable iff (!rst_n)
		force_valid |-> $past(busy))
		else $error("force_valid seen outside a run");

	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done held longer than one cycle");

	busy_low_at_done: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> !busy)
		else $error("busy still high while done pulses");

	busy_falls_with_done: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> done)
		else $error("busy fell without a done pulse");

endmodule

bind md_pair_top md_pair_props u_props (
	.clk(clk), .rst_n(rst_n), .busy(busy), .force_valid(force_valid), .done(done)
);

`default_nettype wire

// File: test/md_pair_tb.sv
`default_nettype none

module md_pair_tb import md_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int BOX  = 640;
	localparam int CUT2 = 40000;

	logic clk, rst_n, load_valid, load_neighbor, clear, start;
	pos_t load_x, load_y, load_z;
	logic busy, force_valid, done;
	logic [IDX_W-1:0] force_home_idx;
	force_t force_x, force_y, force_z;

	// Model of the cell contents
	int home_pos [MAX_PARTICLES][3];
	int nbr_pos [MAX_PARTICLES][3];
	int n_home, n_nbr;

	logic [IDX_W-1:0] exp_idx [$];
	force_t exp_x [$], exp_y [$], exp_z [$];
	bit done_seen;
	bit forces_due;	// Current run sweeps at least one pair
	int errors;
	string test_name;

	md_pair_top #(.BOX_SIZE(BOX), .CUTOFF_2(CUT2)) DUT (
		.clk(clk), .rst_n(rst_n),
		.load_valid(load_valid), .load_neighbor(load_neighbor),
		.load_x(load_x), .load_y(load_y), .load_z(load_z),
		.clear(clear), .start(start), .busy(busy),
		.force_valid(force_valid), .force_home_idx(force_home_idx),
		.force_x(force_x), .force_y(force_y), .force_z(force_z),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic fail_run(input string why);
		errors++;
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic compare_force(input string what, input force_t exp, input force_t act);
		if (exp !== act)
			fail_run($sformatf("[ERROR] %s: %s expected %0d, actual %0d",
				test_name, what, exp, act));
	endtask

	task automatic compare_idx(input logic [IDX_W-1:0] exp, input logic [IDX_W-1:0] act);
		if (exp !== act)
			fail_run($sformatf("[ERROR] %s: home index expected %0d, actual %0d",
				test_name, exp, act));
	endtask

	// Periodic wrap for one axis
	function automatic int min_image(input int home, input int nbr);
		int d;
		d = home - nbr;
		if (d > BOX / 2)
			d = d - BOX;
		else if (d < -(BOX / 2))
			d = d + BOX;
		return d;
	endfunction

	// Total force on home particle h along one axis
	function automatic force_t ref_force(input int h, input int axis);
		int d [3];
		int r2, coef;
		force_t sum;
		sum = 0;
		for (int n = 0; n < n_nbr; n++) begin
			r2 = 0;
			for (int a = 0; a < 3; a++) begin
				d[a] = min_image(home_pos[h][a], nbr_pos[n][a]);
				r2 += d[a] * d[a];
			end
			if (r2 < CUT2 && r2 != 0) begin
				coef = 4095 - (r2 >> 8);	// Table index is r2 without its 8 fraction bits
				sum += (d[axis] * coef) >>> 8;
			end
		end
		return sum;
	endfunction

	// Compare process, outputs are stable at the falling edge
	always @(negedge clk) begin
		if (rst_n && force_valid) begin
			if (exp_idx.size() == 0) begin
				fail_run({test_name, ": force_valid with no force expected"});
			end else begin
				compare_idx(exp_idx.pop_front(), force_home_idx);
				compare_force("force_x", exp_x.pop_front(), force_x);
				compare_force("force_y", exp_y.pop_front(), force_y);
				compare_force("force_z", exp_z.pop_front(), force_z);
			end
		end
		if (rst_n && done) begin
			if (exp_idx.size() != 0)
				fail_run({test_name, ": done came before every home force"});
			if (forces_due && !force_valid)
				fail_run({test_name, ": done came apart from the last home force"});
			done_seen = 1'b1;
		end
	end

	task automatic load_particle(input bit to_nbr, input int x, input int y, input int z);
		@(posedge clk);
		load_valid    <= 1'b1;
		load_neighbor <= to_nbr;
		load_x        <= pos_t'(x);
		load_y        <= pos_t'(y);
		load_z        <= pos_t'(z);
		@(posedge clk);
		load_valid <= 1'b0;
		if (to_nbr && n_nbr < MAX_PARTICLES) begin
			nbr_pos[n_nbr][0] = x;
			nbr_pos[n_nbr][1] = y;
			nbr_pos[n_nbr][2] = z;
			n_nbr++;
		end else if (!to_nbr && n_home < MAX_PARTICLES) begin	// A full cell drops it
			home_pos[n_home][0] = x;
			home_pos[n_home][1] = y;
			home_pos[n_home][2] = z;
			n_home++;
		end
	endtask

	task automatic load_random(input bit to_nbr, input int count);
		for (int i = 0; i < count; i++)
			load_particle(to_nbr, $urandom % BOX, $urandom % BOX, $urandom % BOX);
	endtask

	task automatic clear_cells();
		@(posedge clk);
		clear <= 1'b1;
		@(posedge clk);
		clear <= 1'b0;
		n_home = 0;
		n_nbr  = 0;
	endtask

	task automatic wait_done(input int limit);
		int cycles;
		cycles = 0;
		while (!done_seen) begin
			@(posedge clk);
			cycles++;
			if (cycles > limit)
				fail_run({test_name, ": timeout waiting for done"});
		end
	endtask

	task automatic wait_busy(input int limit);
		int cycles;
		cycles = 0;
		while (!busy) begin
			@(posedge clk);
			cycles++;
			if (cycles > limit)
				fail_run({test_name, ": timeout waiting for busy"});
		end
	endtask

	// Queue the reference results, then pulse start
	task automatic launch_run();
		forces_due = (n_home > 0 && n_nbr > 0);
		if (forces_due) begin
			for (int h = 0; h < n_home; h++) begin
				exp_idx.push_back(IDX_W'(h));
				exp_x.push_back(ref_force(h, 0));
				exp_y.push_back(ref_force(h, 1));
				exp_z.push_back(ref_force(h, 2));
			end
		end
		done_seen = 1'b0;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	initial begin
		void'($urandom(32'h26b59595));
		errors        = 0;
		n_home        = 0;
		n_nbr         = 0;
		rst_n         = 1'b0;
		load_valid    = 1'b0;
		load_neighbor = 1'b0;
		load_x        = '0;
		load_y        = '0;
		load_z        = '0;
		clear         = 1'b0;
		start         = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		test_name = "random_run";
		load_random(1'b0, 8);
		load_random(1'b1, 8);
		launch_run();
		wait_done(200);

		test_name = "box_wrap";
		clear_cells();
		for (int i = 0; i < 3; i++)
			load_particle(1'b0, 3 + 2 * i, 636 - i, 200);
		for (int j = 0; j < 3; j++)
			load_particle(1'b1, 630 - 3 * j, 4 + j, 210 + 4 * j);
		for (int h = 0; h < n_home; h++)
			if (ref_force(h, 0) == 0 || ref_force(h, 1) == 0)
				fail_run("wrap placement gives a zero reference force");
		launch_run();
		wait_done(100);

		test_name = "cutoff";
		clear_cells();
		load_particle(1'b0, 10, 10, 10);
		load_particle(1'b0, 330, 330, 330);
		load_particle(1'b1, 10, 10, 10);	// Same spot as a home particle
		load_particle(1'b1, 330, 330, 330);
		load_particle(1'b1, 210, 10, 10);	// r2 exactly at the cutoff
		for (int h = 0; h < n_home; h++)
			if (ref_force(h, 0) != 0 || ref_force(h, 1) != 0 || ref_force(h, 2) != 0)
				fail_run("cutoff placement gives a nonzero reference force");
		launch_run();
		wait_done(100);

		test_name = "empty_neighbors";
		clear_cells();
		load_random(1'b0, 4);
		launch_run();
		wait_done(20);
		clear_cells();
		load_random(1'b0, 5);
		load_random(1'b1, 6);
		launch_run();
		wait_done(200);

		test_name = "busy_ignore";
		clear_cells();
		load_random(1'b0, MAX_PARTICLES + 1);	// Last one falls off a full cell
		load_random(1'b1, MAX_PARTICLES + 1);
		launch_run();
		wait_busy(20);
		@(posedge clk);
		start <= 1'b1;
		clear <= 1'b1;
		repeat (3) @(posedge clk);
		start <= 1'b0;
		clear <= 1'b0;
		wait_done(1200);

		// Home cell has room, so a load taken mid-run would add a home particle
		clear_cells();
		load_random(1'b0, 2);
		load_random(1'b1, 2);
		launch_run();
		wait_busy(20);
		@(posedge clk);
		load_valid    <= 1'b1;
		load_neighbor <= 1'b0;
		load_x        <= pos_t'(1);
		load_y        <= pos_t'(2);
		load_z        <= pos_t'(3);
		repeat (2) @(posedge clk);
		load_valid <= 1'b0;
		wait_done(100);

		repeat (10) @(posedge clk);	// A stray second run would show up here
		if (errors == 0 && exp_idx.size() == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			fail_run("expected forces left unchecked at the end");
		end
	end

endmodule

`default_nettype wire
